/* Bender.yml */
package:
  name: adc_receive

sources:
  - include_dirs:
      - .
    files:
      - rx_pkg.sv
      - rx_differentiator.sv
      - rx_delay_line.sv
      - rx_channel_mux.sv
      - rx_discriminator.sv
      - rx_capture_buffer.sv
      - rx_wb_regs.sv
      - receive_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - receive_props.sv
      - receive_tb.sv

/* receive_props.sv */
/*
 * concurrent checks on the wishbone handshake and the stream valids
 * bound into receive_top by the bind below
 */
`timescale 1ns/1ps
`default_nettype none

`include "rx_cfg.svh"

module receive_props
  import rx_pkg::*;
(
  input logic                          adc_clk,
  input logic                          rst,
  input logic                          wb_cyc,
  input logic                          wb_stb,
  input logic                          wb_ack,
  input chan_stream_t                  ddt_stream,
  input chan_stream_t                  raw_stream,
  input chan_stream_t                  mux_stream,
  input kept_word_t [`RX_CHANNELS-1:0] kept
);

  int unsigned             assert_errors = 0;
  // high when reset was also seen on the previous edge
  logic                    rst_d = 1'b0;
  logic [`RX_CHANNELS-1:0] kept_valid;

  always @(posedge adc_clk) begin
    rst_d <= rst;
  end

  always_comb begin
    for (int k = 0; k < `RX_CHANNELS; k++) begin
      kept_valid[k] = kept[k].valid;
    end
  end

  ////////////////////////////////////////
  // wishbone
  ////////////////////////////////////////

  ack_with_stb: assert property (@(posedge adc_clk) disable iff (rst)
    wb_ack |-> (wb_cyc && wb_stb))
    else begin
      assert_errors++;
      $error("wishbone ack without an active strobe");
    end

  ack_one_cycle: assert property (@(posedge adc_clk) disable iff (rst)
    wb_ack |=> !wb_ack)
    else begin
      assert_errors++;
      $error("wishbone ack held longer than one cycle");
    end

  ////////////////////////////////////////
  // stream valids in reset
  ////////////////////////////////////////

  stages_quiet: assert property (@(posedge adc_clk)
    (rst && rst_d) |->
      !(ddt_stream.valid || raw_stream.valid || mux_stream.valid || (|kept_valid)))
    else begin
      assert_errors++;
      $error("stage output valid during reset");
    end

endmodule

bind receive_top receive_props props0 (
  .adc_clk   (adc_clk),
  .rst       (rst),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_ack    (wb_ack),
  .ddt_stream(ddt_stream),
  .raw_stream(raw_stream),
  .mux_stream(mux_stream),
  .kept      (kept)
);

`default_nettype wire

/* receive_tb.sv */
/*
 * testbench for receive_top, random adc words checked against a software model
 * configures the chain and reads back the capture buffer over wishbone
 */
`timescale 1ns/1ps
`default_nettype none

`include "rx_cfg.svh"

module receive_tb
  import rx_pkg::*;
();

  localparam int CH         = `RX_CHANNELS;
  localparam int LANES      = `RX_LANES;
  localparam int SW         = `RX_SAMPLE_W;
  localparam int SRC_W      = `RX_SRC_W;
  localparam int CW         = `RX_COUNT_W;
  localparam int DEPTH      = `RX_BUF_DEPTH;
  localparam int ADR_CTRL   = 0;
  localparam int ADR_MASK   = 1;
  localparam int ADR_MUX    = 2;
  localparam int ADR_THRESH = 3;
  localparam int ADR_STATUS = ADR_THRESH + CH;
  localparam int ADR_BUF    = 16;

  // words per test, each stimulus call adds a flush
  localparam int FLUSH      = 6;
  localparam int T2_WORDS   = 40;
  localparam int T3_WORDS   = 40;
  localparam int T4_WORDS   = 20;
  localparam int T5_WORDS   = 26;
  localparam int ALL_WORDS  = T2_WORDS + T3_WORDS + T4_WORDS + T5_WORDS + 6 * FLUSH;
  // margin covers the wishbone configuration and readback
  localparam int TIMEOUT_NS = ALL_WORDS * 4 + 20000;

  logic                    adc_clk;
  logic                    rst;
  chan_stream_t            adc_in;
  logic [CH-1:0]           digital_triggers;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [`RX_WB_ADR_W-1:0] wb_adr;
  logic [`RX_WB_DAT_W-1:0] wb_dat_w;
  logic [`RX_WB_DAT_W-1:0] wb_dat_r;
  logic                    wb_ack;

  integer seed;
  int     errors;
  int     checks;

  // software model state
  sample_t                      mdl_last [CH];
  int                           mdl_tstamp;
  int                           mdl_count;
  logic                         mdl_armed;
  logic                         mdl_triggered;
  logic [CH-1:0]                mdl_bypass;
  logic [CH-1:0]                mdl_mask;
  logic [CH-1:0][SRC_W-1:0]     mdl_mux;
  logic [CH-1:0][SW-1:0]        mdl_thresh;
  logic [31:0]                  exp_data [$];
  logic [31:0]                  exp_tag [$];

  receive_top dut0 (
    .adc_clk         (adc_clk),
    .rst             (rst),
    .adc_in          (adc_in),
    .digital_triggers(digital_triggers),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack)
  );

  initial begin
    adc_clk = 1'b0;
  end

  always #2 adc_clk = ~adc_clk;

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // checks and bus access
  ////////////////////////////////////////

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %0t ns: %s, read %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d mismatches", name, errors - errors_before);
    end
  endtask

  task automatic bus_cycle(input int adr, input logic we, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited;
    @(negedge adc_clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = `RX_WB_ADR_W'(adr);
    wb_dat_w = wdata;
    waited   = 0;
    do begin
      @(negedge adc_clk);
      waited++;
    end while (!wb_ack && waited < 16);
    if (!wb_ack) begin
      errors++;
      $display("wishbone slave gave no ack at address %0d within 16 cycles", adr);
    end
    rdata = wb_dat_r;
    // strobe stays up over the edge that completes the transfer
    @(negedge adc_clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic reg_write(input int adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(adr, 1'b1, data, unused);
  endtask

  task automatic reg_read(input int adr, output logic [31:0] data);
    bus_cycle(adr, 1'b0, '0, data);
  endtask

  task automatic set_config(input logic [CH-1:0] bypass, input logic [CH-1:0] mask,
                            input logic [CH-1:0][SRC_W-1:0] mux,
                            input logic [CH-1:0][SW-1:0] th);
    reg_write(ADR_CTRL, 32'({bypass, 1'b0}));
    reg_write(ADR_MASK, 32'(mask));
    reg_write(ADR_MUX, 32'(mux));
    for (int k = 0; k < CH; k++) begin
      reg_write(ADR_THRESH + k, 32'(th[k]));
    end
    mdl_bypass = bypass;
    mdl_mask   = mask;
    mdl_mux    = mux;
    mdl_thresh = th;
  endtask

  task automatic arm_capture();
    reg_write(ADR_CTRL, 32'({mdl_bypass, 1'b1}));
    mdl_armed     = 1'b1;
    mdl_triggered = 1'b0;
    mdl_count     = 0;
    exp_data.delete();
    exp_tag.delete();
  endtask

  ////////////////////////////////////////
  // chain model, one call per cycle
  ////////////////////////////////////////

  task automatic model_step(input chan_stream_t w, input logic [CH-1:0] trig);
    sample_word_t raw [CH];
    sample_word_t ddt [CH];
    sample_word_t picked;
    sample_t      s;
    logic         hit;
    logic         cap;
    logic         keep;
    int           src;
    int           mag;
    hit = mdl_armed && ((trig & mdl_mask) != '0);
    cap = mdl_triggered || hit;
    if (w.valid) begin
      for (int c = 0; c < CH; c++) begin
        raw[c]    = w.data[c];
        // lane 0 carries over from the previous valid word
        ddt[c][0] = w.data[c][0] - mdl_last[c];
        for (int l = 1; l < LANES; l++) begin
          ddt[c][l] = w.data[c][l] - w.data[c][l-1];
        end
      end
      for (int k = 0; k < CH; k++) begin
        src    = mdl_mux[k];
        picked = (src < CH) ? raw[src] : ddt[src - CH];
        keep   = mdl_bypass[k];
        for (int l = 0; l < LANES; l++) begin
          s   = picked[l];
          mag = s;
          if (mag < 0) begin
            mag = -mag;
          end
          if (mag > int'(mdl_thresh[k])) begin
            keep = 1'b1;
          end
        end
        if (cap && keep && mdl_count < DEPTH) begin
          exp_data.push_back(32'(picked));
          exp_tag.push_back((32'(k) << `RX_TSTAMP_W) | 32'(mdl_tstamp));
          mdl_count++;
        end
      end
      for (int c = 0; c < CH; c++) begin
        mdl_last[c] = w.data[c][LANES-1];
      end
      mdl_tstamp++;
    end
    if (hit) begin
      mdl_armed     = 1'b0;
      mdl_triggered = 1'b1;
    end
  endtask

  // random words, trig_bits on word trig_at, unmasked noise elsewhere
  task automatic drive_words(input int n, input int trig_at, input logic [CH-1:0] trig_bits);
    for (int i = 0; i < n + FLUSH; i++) begin
      @(negedge adc_clk);
      if (i < n) begin
        adc_in.valid = (i == trig_at) || (($random(seed) & 3) != 0);
        for (int c = 0; c < CH; c++) begin
          for (int l = 0; l < LANES; l++) begin
            adc_in.data[c][l] = SW'($random(seed));
          end
        end
        digital_triggers = (i == trig_at) ? trig_bits : (CH'($random(seed)) & ~mdl_mask);
      end else begin
        adc_in           = '0;
        digital_triggers = '0;
      end
      model_step(adc_in, digital_triggers);
    end
  endtask

  task automatic check_capture(input string what);
    logic [31:0] rd;
    logic [31:0] status_exp;
    status_exp         = 32'(mdl_count);
    status_exp[CW]     = mdl_armed;
    status_exp[CW + 1] = mdl_triggered;
    status_exp[CW + 2] = (mdl_count == DEPTH);
    reg_read(ADR_STATUS, rd);
    check_value(rd, status_exp, {what, ", status"});
    for (int i = 0; i < mdl_count; i++) begin
      reg_read(ADR_BUF + 2 * i, rd);
      check_value(rd, exp_data[i], $sformatf("%s, samples of entry %0d", what, i));
      reg_read(ADR_BUF + 2 * i + 1, rd);
      check_value(rd, exp_tag[i], $sformatf("%s, channel and timestamp of entry %0d", what, i));
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0]              rd;
    int                       mark;
    logic [CH-1:0][SW-1:0]    th;
    logic [CH-1:0][SRC_W-1:0] mux_id;
    logic [CH-1:0][SRC_W-1:0] mux_ddt;
    seed             = 32'h85d40f9f;
    errors           = 0;
    checks           = 0;
    rst              = 1'b1;
    adc_in           = '0;
    digital_triggers = '0;
    wb_cyc           = 1'b0;
    wb_stb           = 1'b0;
    wb_we            = 1'b0;
    wb_adr           = '0;
    wb_dat_w         = '0;
    mdl_tstamp       = 0;
    mdl_count        = 0;
    mdl_armed        = 1'b0;
    mdl_triggered    = 1'b0;
    mdl_bypass       = '0;
    mdl_mask         = '0;
    mdl_thresh       = '1;
    for (int k = 0; k < CH; k++) begin
      mdl_last[k] = '0;
      mux_id[k]   = SRC_W'(k);
      // crossed derivative routing
      mux_ddt[k]  = SRC_W'(CH + (CH - 1 - k));
    end
    mdl_mux = mux_id;
    repeat (8) @(posedge adc_clk);
    @(negedge adc_clk);
    rst = 1'b0;

    // register access
    mark = errors;
    reg_read(ADR_STATUS, rd);
    check_value(rd, 32'h0, "status after reset");
    for (int k = 0; k < CH; k++) begin
      th[k] = SW'($random(seed));
    end
    set_config(CH'($random(seed)), CH'($random(seed)), (CH*SRC_W)'($random(seed)), th);
    reg_read(ADR_CTRL, rd);
    check_value(rd, 32'({mdl_bypass, 1'b0}), "control readback");
    reg_read(ADR_MASK, rd);
    check_value(rd, 32'(mdl_mask), "trigger mask readback");
    reg_read(ADR_MUX, rd);
    check_value(rd, 32'(mdl_mux), "mux source readback");
    for (int k = 0; k < CH; k++) begin
      reg_read(ADR_THRESH + k, rd);
      check_value(rd, 32'(mdl_thresh[k]), $sformatf("threshold %0d readback", k));
    end
    report_test("register access", mark);

    // bypass capture until full
    mark = errors;
    set_config('1, CH'(1), mux_id, '1);
    arm_capture();
    drive_words(T2_WORDS, 4, CH'(1));
    check_capture("bypass capture");
    reg_read(ADR_STATUS, rd);
    check_value(32'(rd[CW + 2]), 32'h1, "full flag after bypass capture");
    report_test("bypass capture", mark);

    // threshold filtering
    mark = errors;
    for (int k = 0; k < CH; k++) begin
      th[k] = 16'h4000 | (SW'($random(seed)) & 16'h3fff);
    end
    set_config('0, '1, mux_id, th);
    arm_capture();
    drive_words(T3_WORDS, 2, CH'(1));
    check_capture("threshold filtering");
    report_test("threshold filtering", mark);

    // derivative routing
    mark = errors;
    set_config('1, CH'(2), mux_ddt, '1);
    arm_capture();
    drive_words(T4_WORDS, 3, CH'(2));
    check_capture("derivative routing");
    report_test("derivative routing", mark);

    // trigger masking and re-arm
    mark = errors;
    set_config('1, CH'(1), mux_id, '1);
    arm_capture();
    drive_words(10, 5, CH'(2));
    check_capture("unmasked trigger");
    drive_words(6, 1, CH'(1));
    check_capture("masked trigger before re-arm");
    arm_capture();
    check_capture("re-arm");
    drive_words(10, 2, CH'(1));
    check_capture("masked trigger after re-arm");
    report_test("trigger masking and re-arm", mark);

    check_value(dut0.props0.assert_errors, 32'h0, "concurrent assertion failures");
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* receive_top.sv */
/*
 * receive chain top, adc stream in, wishbone for config and readout
 * input word to discriminator output is three cycles
 */
`timescale 1ns/1ps
`default_nettype none

`include "rx_cfg.svh"

module receive_top
  import rx_pkg::*;
(
  input  logic                    adc_clk,
  input  logic                    rst,
  input  chan_stream_t            adc_in,
  input  logic [`RX_CHANNELS-1:0] digital_triggers,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [`RX_WB_ADR_W-1:0] wb_adr,
  input  logic [`RX_WB_DAT_W-1:0] wb_dat_w,
  output logic [`RX_WB_DAT_W-1:0] wb_dat_r,
  output logic                    wb_ack
);

  chan_stream_t                  ddt_stream;
  chan_stream_t                  raw_stream;
  chan_stream_t                  mux_stream;
  kept_word_t [`RX_CHANNELS-1:0] kept;
  rx_config_t                    cfg;
  rx_status_t                    status;
  logic [`RX_ENTRY_W-1:0]        buf_addr;
  kept_word_t                    buf_data;

  ////////////////////////////////////////
  // realtime path
  ////////////////////////////////////////

  rx_differentiator differentiator_i (
    .adc_clk (adc_clk),
    .rst     (rst),
    .data_in (adc_in),
    .data_out(ddt_stream)
  );

  // raw copy held back to match the differentiator
  rx_delay_line #(
    .payload_t(chan_stream_t),
    .DEPTH    (`RX_ALIGN_DELAY)
  ) raw_delay_i (
    .adc_clk(adc_clk),
    .rst    (rst),
    .din    (adc_in),
    .dout   (raw_stream)
  );

  rx_channel_mux channel_mux_i (
    .adc_clk(adc_clk),
    .rst    (rst),
    .raw_in (raw_stream),
    .ddt_in (ddt_stream),
    .sel    (cfg.mux_src),
    .out    (mux_stream)
  );

  rx_discriminator discriminator_i (
    .adc_clk   (adc_clk),
    .rst       (rst),
    .data_in   (mux_stream),
    .thresholds(cfg.threshold),
    .bypass    (cfg.bypass),
    .kept      (kept)
  );

  rx_capture_buffer capture_buffer_i (
    .adc_clk  (adc_clk),
    .rst      (rst),
    .kept     (kept),
    .triggers (digital_triggers),
    .trig_mask(cfg.trig_mask),
    .arm      (cfg.arm),
    .status   (status),
    .rd_addr  (buf_addr),
    .rd_data  (buf_data)
  );

  ////////////////////////////////////////
  // register block
  ////////////////////////////////////////

  rx_wb_regs wb_regs_i (
    .adc_clk (adc_clk),
    .rst     (rst),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack),
    .cfg     (cfg),
    .status  (status),
    .buf_addr(buf_addr),
    .buf_data(buf_data)
  );

endmodule

`default_nettype wire

/* rx_capture_buffer.sv */
/*
 * capture memory for kept words, started by a masked trigger after arming
 * entries fill in channel order until full, read back through a registered port
 */
`timescale 1ns/1ps
`default_nettype none

`include "rx_cfg.svh"

module rx_capture_buffer
  import rx_pkg::*;
(
  input  logic                          adc_clk,
  input  logic                          rst,
  input  kept_word_t [`RX_CHANNELS-1:0] kept,
  input  logic [`RX_CHANNELS-1:0]       triggers,
  input  logic [`RX_CHANNELS-1:0]       trig_mask,
  input  logic                          arm,
  output rx_status_t                    status,
  input  logic [`RX_ENTRY_W-1:0]        rd_addr,
  output kept_word_t                    rd_data
);

  // raw or derivative stage, mux, discriminator
  localparam int TRIG_DELAY = `RX_ALIGN_DELAY + 2;

  kept_word_t mem [`RX_BUF_DEPTH];

  logic [`RX_CHANNELS-1:0] trig_dly;
  logic                    armed;
  logic                    triggered;
  logic                    trig_hit;
  logic                    capture_en;
  logic [`RX_COUNT_W-1:0]  count;
  logic [`RX_COUNT_W-1:0]  count_next;
  logic [`RX_CHANNELS-1:0] wr_en;
  logic [`RX_ENTRY_W-1:0]  wr_ptr [`RX_CHANNELS];

  // line the trigger up with the discriminator output
  rx_delay_line #(
    .payload_t(logic [`RX_CHANNELS-1:0]),
    .DEPTH    (TRIG_DELAY)
  ) trig_delay_i (
    .adc_clk(adc_clk),
    .rst    (rst),
    .din    (triggers),
    .dout   (trig_dly)
  );

  assign trig_hit   = armed & |(trig_dly & trig_mask);
  // the trigger word itself is already a candidate
  assign capture_en = triggered | trig_hit;

  ////////////////////////////////////////
  // write slots, channel 0 first
  ////////////////////////////////////////

  always_comb begin
    count_next = count;
    for (int k = 0; k < `RX_CHANNELS; k++) begin
      wr_en[k]  = 1'b0;
      wr_ptr[k] = count_next[`RX_ENTRY_W-1:0];
      if (capture_en && kept[k].valid && count_next < `RX_BUF_DEPTH) begin
        wr_en[k]   = 1'b1;
        count_next = count_next + 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    for (int k = 0; k < `RX_CHANNELS; k++) begin
      if (wr_en[k] && !arm) begin
        mem[wr_ptr[k]] <= kept[k];
      end
    end
    rd_data <= mem[rd_addr];
  end

  ////////////////////////////////////////
  // arm / trigger state
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      armed     <= 1'b0;
      triggered <= 1'b0;
      count     <= '0;
    end else if (arm) begin
      armed     <= 1'b1;
      triggered <= 1'b0;
      count     <= '0;
    end else begin
      if (trig_hit) begin
        armed     <= 1'b0;
        triggered <= 1'b1;
      end
      count <= count_next;
    end
  end

  assign status.count     = count;
  assign status.armed     = armed;
  assign status.triggered = triggered;
  assign status.full      = (count == `RX_BUF_DEPTH);

endmodule

`default_nettype wire

/* rx_cfg.svh */
/*
 * size and width constants for the receive chain
 * include wherever a module or the package needs a channel count or width
 */
`ifndef RX_CFG_SVH
`define RX_CFG_SVH

// physical and logical channels
`define RX_CHANNELS     2
// parallel samples per word
`define RX_LANES        2
`define RX_SAMPLE_W     16
`define RX_TSTAMP_W     24
`define RX_BUF_DEPTH    32
// raw path delay, matches the differentiator
`define RX_ALIGN_DELAY  1

// derived widths
`define RX_SRC_W        ($clog2(2*`RX_CHANNELS))
`define RX_CHAN_W       ($clog2(`RX_CHANNELS))
`define RX_ENTRY_W      ($clog2(`RX_BUF_DEPTH))
`define RX_COUNT_W      (`RX_ENTRY_W + 1)

// wishbone bus
`define RX_WB_ADR_W     8
`define RX_WB_DAT_W     32

`endif

/* rx_channel_mux.sv */
/*
 * picks each logical channel from the raw or the derivative sources
 * sel values below the channel count are raw, the rest derivative
 */
`timescale 1ns/1ps
`default_nettype none

`include "rx_cfg.svh"

module rx_channel_mux
  import rx_pkg::*;
(
  input  logic                                   adc_clk,
  input  logic                                   rst,
  input  chan_stream_t                           raw_in,
  input  chan_stream_t                           ddt_in,
  input  logic [`RX_CHANNELS-1:0][`RX_SRC_W-1:0] sel,
  output chan_stream_t                           out
);

  // raw channels low, derivative channels high
  sample_word_t [2*`RX_CHANNELS-1:0] sources;

  assign sources = {ddt_in.data, raw_in.data};

  always_ff @(posedge adc_clk) begin
    for (int k = 0; k < `RX_CHANNELS; k++) begin
      out.data[k] <= sources[sel[k]];
    end
    if (rst) begin
      out.valid <= 1'b0;
    end else begin
      // both paths are aligned, so the valids agree
      out.valid <= raw_in.valid & ddt_in.valid;
    end
  end

endmodule

`default_nettype wire

/* rx_delay_line.sv */
/*
 * fixed-length register pipeline for any payload type
 * used for the raw stream and for the trigger vector
 */
`timescale 1ns/1ps
`default_nettype none

module rx_delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     adc_clk,
  input  logic     rst,
  input  payload_t din,
  output payload_t dout
);

  payload_t stages [DEPTH];

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stages[i] <= '0;
      end
    end else begin
      stages[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign dout = stages[DEPTH-1];

endmodule

`default_nettype wire

/* rx_differentiator.sv */
/*
 * first difference of each channel across lanes and across words
 * lane 0 is taken against the last lane of the previous valid word
 */
`timescale 1ns/1ps
`default_nettype none

`include "rx_cfg.svh"

module rx_differentiator
  import rx_pkg::*;
(
  input  logic         adc_clk,
  input  logic         rst,
  input  chan_stream_t data_in,
  output chan_stream_t data_out
);

  // last sample of the previous valid word, per channel
  sample_t      [`RX_CHANNELS-1:0] last_sample;
  sample_word_t [`RX_CHANNELS-1:0] prev_word;

  // preceding sample for every lane
  always_comb begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      prev_word[c][0] = last_sample[c];
      for (int l = 1; l < `RX_LANES; l++) begin
        prev_word[c][l] = data_in.data[c][l-1];
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    // wraps modulo the sample width
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      for (int l = 0; l < `RX_LANES; l++) begin
        data_out.data[c][l] <= data_in.data[c][l] - prev_word[c][l];
      end
    end
    if (rst) begin
      data_out.valid <= 1'b0;
      last_sample    <= '0;
    end else begin
      data_out.valid <= data_in.valid;
      if (data_in.valid) begin
        for (int c = 0; c < `RX_CHANNELS; c++) begin
          last_sample[c] <= data_in.data[c][`RX_LANES-1];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rx_discriminator.sv */
/*
 * per-channel threshold test with timestamping of accepted words
 * a kept word carries its channel index and the count of words before it
 */
`timescale 1ns/1ps
`default_nettype none

`include "rx_cfg.svh"

module rx_discriminator
  import rx_pkg::*;
(
  input  logic                                     adc_clk,
  input  logic                                     rst,
  input  chan_stream_t                             data_in,
  input  logic [`RX_CHANNELS-1:0][`RX_SAMPLE_W-1:0] thresholds,
  input  logic [`RX_CHANNELS-1:0]                  bypass,
  output kept_word_t [`RX_CHANNELS-1:0]            kept
);

  logic [`RX_TSTAMP_W-1:0] tstamp;
  logic [`RX_CHANNELS-1:0] over;

  // |s| in one extra bit, so the most negative sample fits
  function automatic logic [`RX_SAMPLE_W:0] magnitude(input sample_t s);
    logic [`RX_SAMPLE_W:0] ext;
    ext = {s[`RX_SAMPLE_W-1], s};
    return s[`RX_SAMPLE_W-1] ? -ext : ext;
  endfunction

  ////////////////////////////////////////
  // threshold test
  ////////////////////////////////////////

  // threshold is unsigned, strictly greater keeps the word
  always_comb begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      over[c] = bypass[c];
      for (int l = 0; l < `RX_LANES; l++) begin
        if (magnitude(data_in.data[c][l]) > {1'b0, thresholds[c]}) begin
          over[c] = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // outputs and timestamp counter
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      kept[c].chan   <= `RX_CHAN_W'(c);
      kept[c].data   <= data_in.data[c];
      kept[c].tstamp <= tstamp;
    end
    if (rst) begin
      tstamp <= '0;
      for (int c = 0; c < `RX_CHANNELS; c++) begin
        kept[c].valid <= 1'b0;
      end
    end else begin
      // counts accepted words, not cycles
      if (data_in.valid) begin
        tstamp <= tstamp + 1'b1;
      end
      for (int c = 0; c < `RX_CHANNELS; c++) begin
        kept[c].valid <= data_in.valid & over[c];
      end
    end
  end

endmodule

`default_nettype wire

/* rx_pkg.sv */
/*
 * shared stream, config and status types for the receive chain
 */
`default_nettype none

`include "rx_cfg.svh"

package rx_pkg;

  typedef logic signed [`RX_SAMPLE_W-1:0] sample_t;

  // one channel's parallel lanes, lane 0 is the oldest sample
  typedef sample_t [`RX_LANES-1:0] sample_word_t;

  // realtime stream between stages, one valid for all channels
  typedef struct packed {
    logic                                  valid;
    sample_word_t [`RX_CHANNELS-1:0]       data;
  } chan_stream_t;

  typedef struct packed {
    logic                                  valid;
    logic [`RX_CHAN_W-1:0]                 chan;
    sample_word_t                          data;
    logic [`RX_TSTAMP_W-1:0]               tstamp;
  } kept_word_t;

  typedef struct packed {
    logic [`RX_CHANNELS-1:0][`RX_SAMPLE_W-1:0] threshold;
    logic [`RX_CHANNELS-1:0][`RX_SRC_W-1:0]    mux_src;
    logic [`RX_CHANNELS-1:0]                   bypass;
    logic [`RX_CHANNELS-1:0]                   trig_mask;
    logic                                      arm;
  } rx_config_t;

  // count sits in the low bits when read as a register
  typedef struct packed {
    logic                                  full;
    logic                                  triggered;
    logic                                  armed;
    logic [`RX_COUNT_W-1:0]                count;
  } rx_status_t;

endpackage

`default_nettype wire

/* rx_wb_regs.sv */
/*
 * wishbone classic register block, config out, status and buffer reads in
 * ack comes one cycle wide, two cycles after the request is seen
 */
`timescale 1ns/1ps
`default_nettype none

`include "rx_cfg.svh"

module rx_wb_regs
  import rx_pkg::*;
(
  input  logic                    adc_clk,
  input  logic                    rst,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [`RX_WB_ADR_W-1:0] wb_adr,
  input  logic [`RX_WB_DAT_W-1:0] wb_dat_w,
  output logic [`RX_WB_DAT_W-1:0] wb_dat_r,
  output logic                    wb_ack,
  output rx_config_t              cfg,
  input  rx_status_t              status,
  output logic [`RX_ENTRY_W-1:0]  buf_addr,
  input  kept_word_t              buf_data
);

  // word addresses
  localparam int ADR_CTRL   = 0;
  localparam int ADR_MASK   = 1;
  localparam int ADR_MUX    = 2;
  localparam int ADR_THRESH = 3;
  localparam int ADR_STATUS = ADR_THRESH + `RX_CHANNELS;
  localparam int ADR_BUF    = 16;
  localparam int BUF_WORDS  = 2 * `RX_BUF_DEPTH;

  logic                    pending;
  logic [`RX_WB_ADR_W-1:0] buf_offset;
  logic                    buf_hit;
  logic [`RX_WB_DAT_W-1:0] tag_word;
  logic [`RX_WB_DAT_W-1:0] rd_word;

  // two words per entry, odd word is the tag
  assign buf_offset = wb_adr - `RX_WB_ADR_W'(ADR_BUF);
  assign buf_hit    = (wb_adr >= ADR_BUF) && (buf_offset < BUF_WORDS);
  assign buf_addr   = buf_offset[`RX_ENTRY_W:1];
  assign tag_word   = `RX_WB_DAT_W'({buf_data.chan, buf_data.tstamp});

  ////////////////////////////////////////
  // read decode
  ////////////////////////////////////////

  always_comb begin
    rd_word = '0;
    if (buf_hit) begin
      rd_word = wb_adr[0] ? tag_word : `RX_WB_DAT_W'(buf_data.data);
    end else if (wb_adr == ADR_CTRL) begin
      // arm always reads back as zero
      rd_word = `RX_WB_DAT_W'({cfg.bypass, 1'b0});
    end else if (wb_adr == ADR_MASK) begin
      rd_word = `RX_WB_DAT_W'(cfg.trig_mask);
    end else if (wb_adr == ADR_MUX) begin
      rd_word = `RX_WB_DAT_W'(cfg.mux_src);
    end else if (wb_adr == ADR_STATUS) begin
      rd_word = `RX_WB_DAT_W'(status);
    end
    for (int k = 0; k < `RX_CHANNELS; k++) begin
      if (wb_adr == ADR_THRESH + k) begin
        rd_word = `RX_WB_DAT_W'(cfg.threshold[k]);
      end
    end
  end

  ////////////////////////////////////////
  // handshake and config writes
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (pending) begin
      wb_dat_r <= rd_word;
    end
    if (rst) begin
      pending       <= 1'b0;
      wb_ack        <= 1'b0;
      cfg.threshold <= '1;
      cfg.bypass    <= '0;
      cfg.trig_mask <= '0;
      cfg.arm       <= 1'b0;
      for (int k = 0; k < `RX_CHANNELS; k++) begin
        cfg.mux_src[k] <= `RX_SRC_W'(k);
      end
    end else begin
      // first cycle fetches the buffer entry, second answers
      pending <= wb_cyc & wb_stb & ~pending & ~wb_ack;
      wb_ack  <= pending;
      cfg.arm <= 1'b0;
      if (pending && wb_we) begin
        if (wb_adr == ADR_CTRL) begin
          cfg.arm    <= wb_dat_w[0];
          cfg.bypass <= wb_dat_w[`RX_CHANNELS:1];
        end
        if (wb_adr == ADR_MASK) begin
          cfg.trig_mask <= wb_dat_w[`RX_CHANNELS-1:0];
        end
        if (wb_adr == ADR_MUX) begin
          for (int k = 0; k < `RX_CHANNELS; k++) begin
            cfg.mux_src[k] <= wb_dat_w[k*`RX_SRC_W +: `RX_SRC_W];
          end
        end
        for (int k = 0; k < `RX_CHANNELS; k++) begin
          if (wb_adr == ADR_THRESH + k) begin
            cfg.threshold[k] <= wb_dat_w[`RX_SAMPLE_W-1:0];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
rx_pkg.sv
rx_differentiator.sv
rx_delay_line.sv
rx_channel_mux.sv
rx_discriminator.sv
rx_capture_buffer.sv
rx_wb_regs.sv
receive_top.sv
receive_props.sv
receive_tb.sv
